// ==== hw/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////////////////////////////////////////
  localparam int ADDR_W         = 32;
  localparam int DATA_W         = 32;
  localparam int LINE_BYTES     = 16;
  localparam int WAYS           = 2;
  localparam int SETS           = 16;
  // one beat per word, so this is also the burst length
  localparam int WORDS_PER_LINE = LINE_BYTES / (DATA_W / 8);
  localparam int OFF_W          = $clog2(LINE_BYTES);
  localparam int IDX_W          = $clog2(SETS);
  localparam int WORD_W         = $clog2(WORDS_PER_LINE);
  localparam int TAG_W          = ADDR_W - IDX_W - OFF_W;
  localparam int LINE_W         = 8 * LINE_BYTES;

  // fetch address, seen by lookup or as a line number
  typedef union packed {
    struct packed {
      logic [TAG_W-1:0]        tag;
      logic [IDX_W-1:0]        idx;
      logic [WORD_W-1:0]       word;
      logic [OFF_W-WORD_W-1:0] byte_off;
    } lookup;
    struct packed {
      logic [ADDR_W-OFF_W-1:0] num;
      logic [OFF_W-1:0]        off;
    } line;
  } icache_addr_u;

  ////////////////////////////////////////////////////////////////////////////
  // state encodings
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {ARMED, FLUSH, MISS, RECOVER} ctrl_state_e;

  typedef enum logic [1:0] {IDLE, WAIT_GNT, BURST} burst_state_e;

endpackage

`default_nettype wire

// ==== hw/icache_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl
  import icache_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              flush_i,
  input  logic [WAYS-1:0]   way_hit_i,
  input  logic              fill_done_i,
  input  logic              fill_err_i,
  output logic              ack_o,
  output logic              err_o,
  output logic              fill_start_o,
  output logic [IDX_W-1:0]  lookup_idx_o,
  output logic [WAYS-1:0]   fill_way_o,
  output logic              fill_we_o,
  output logic              inval_o
);

  ctrl_state_e      state_q;
  ctrl_state_e      state_d;
  icache_addr_u     fetch_addr;
  logic             req_q;
  logic             flush_pend_q;
  logic             hit;
  logic [IDX_W-1:0] miss_idx_q;
  logic [WAYS-1:0]  fill_way_q;
  logic [19:0]      lfsr_q;

  assign fetch_addr = addr_i;
  assign hit        = |way_hit_i;

  // tags were read last cycle, so a pending request can be answered now
  assign ack_o        = (state_q == ARMED) && req_q && hit;
  assign err_o        = (state_q == MISS) && fill_err_i;
  assign fill_start_o = (state_q == MISS);
  assign fill_we_o    = (state_q == MISS) && fill_done_i && !fill_err_i;
  assign inval_o      = (state_q == FLUSH);
  // miss index is held while the burst runs
  assign lookup_idx_o = (state_q == MISS) ? miss_idx_q : fetch_addr.lookup.idx;
  assign fill_way_o   = fill_way_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ARMED: begin
        // flush wins and the miss is seen again after it
        if (flush_i || flush_pend_q) begin
          state_d = FLUSH;
        end else if (req_q && !hit) begin
          state_d = MISS;
        end
      end
      FLUSH:   state_d = ARMED;
      MISS: begin
        if (fill_err_i) begin
          state_d = ARMED;
        end else if (fill_done_i) begin
          state_d = RECOVER;
        end
      end
      // one cycle to re-read the freshly written line
      default: state_d = ARMED;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ARMED;
      req_q        <= 1'b0;
      flush_pend_q <= 1'b0;
      fill_way_q   <= WAYS'(1);
      lfsr_q       <= '0;
    end else begin
      state_q      <= state_d;
      req_q        <= req_i && !ack_o && !err_o;
      // flush outside ARMED waits here
      flush_pend_q <= (flush_pend_q || flush_i) && (state_q != ARMED);
      // random replacement frozen during a fill
      if (state_q != MISS) begin
        lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ~^ lfsr_q[16]};
      end
      if (state_q == ARMED && state_d == MISS) begin
        fill_way_q <= WAYS'(1) << lfsr_q[$clog2(WAYS)-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ARMED && state_d == MISS) begin
      miss_idx_q <= fetch_addr.lookup.idx;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  // one answer per fetch
  a_one_answer: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_o || err_o) |=> !(ack_o || err_o));

  // an install belongs to a live fetch
  a_fill_we_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_we_o |-> req_q);

endmodule

`default_nettype wire

// ==== hw/icache_tag_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_tag_array
  import icache_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [IDX_W-1:0] lookup_idx_i,
  input  logic [TAG_W-1:0] tag_i,
  input  logic [WAYS-1:0]  fill_way_i,
  input  logic             fill_we_i,
  input  logic             inval_i,
  output logic [WAYS-1:0]  way_hit_o
);

  // index of the read in flight, for valid bits and bypass
  logic [IDX_W-1:0] idx_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else begin
      idx_q <= lookup_idx_i;
    end
  end

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    logic [TAG_W-1:0] mem_q [SETS];
    logic [TAG_W-1:0] rd_tag_q;
    logic [TAG_W-1:0] byp_tag_q;
    logic [IDX_W-1:0] byp_idx_q;
    logic [TAG_W-1:0] way_tag;
    logic [SETS-1:0]  valid_q;

    // tag ram, read returns the old word on a same-cycle write
    always_ff @(posedge clk_i) begin
      if (fill_we_i && fill_way_i[w]) begin
        mem_q[lookup_idx_i] <= tag_i;
        byp_tag_q           <= tag_i;
        byp_idx_q           <= lookup_idx_i;
      end
      rd_tag_q <= mem_q[lookup_idx_i];
    end

    // valid flops, flush clears the whole way at once
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q <= '0;
      end else if (inval_i) begin
        valid_q <= '0;
      end else if (fill_we_i && fill_way_i[w]) begin
        valid_q[lookup_idx_i] <= 1'b1;
      end
    end

    // last written tag covers the read-after-write case
    assign way_tag      = (idx_q == byp_idx_q) ? byp_tag_q : rd_tag_q;
    assign way_hit_o[w] = valid_q[idx_q] && (way_tag == tag_i);
  end

  // a line is only installed after a miss in both ways
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(way_hit_o));

endmodule

`default_nettype wire

// ==== hw/icache_data_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_data_array
  import icache_pkg::*;
(
  input  logic              clk_i,
  input  logic [IDX_W-1:0]  lookup_idx_i,
  input  logic [WORD_W-1:0] word_sel_i,
  input  logic [WAYS-1:0]   fill_way_i,
  input  logic              fill_we_i,
  input  logic [LINE_W-1:0] line_i,
  input  logic [WAYS-1:0]   way_hit_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [LINE_W-1:0] way_line [WAYS];
  logic [LINE_W-1:0] hit_line;

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    logic [LINE_W-1:0] mem_q [SETS];
    logic [LINE_W-1:0] rd_q;

    // whole line written in one go at the end of a fill
    always_ff @(posedge clk_i) begin
      if (fill_we_i && fill_way_i[w]) begin
        mem_q[lookup_idx_i] <= line_i;
      end
      rd_q <= mem_q[lookup_idx_i];
    end

    // masked by this way's hit
    assign way_line[w] = rd_q & {LINE_W{way_hit_i[w]}};
  end

  // and-or mux, hit is one-hot
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < WAYS; w++) begin
      hit_line = hit_line | way_line[w];
    end
  end

  // word pick from the fetch address
  assign rdata_o = hit_line[word_sel_i*DATA_W +: DATA_W];

endmodule

`default_nettype wire

// ==== hw/icache_burst.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_burst
  import icache_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              fill_start_i,
  input  logic [ADDR_W-1:0] miss_addr_i,
  output logic              bus_req_o,
  output logic [ADDR_W-1:0] bus_addr_o,
  input  logic              bus_gnt_i,
  input  logic              bus_ack_i,
  input  logic [DATA_W-1:0] bus_rdata_i,
  input  logic              bus_err_i,
  output logic              fill_done_o,
  output logic              fill_err_o,
  output logic [LINE_W-1:0] line_o
);

  burst_state_e      state_q;
  icache_addr_u      miss_addr;
  logic [ADDR_W-1:0] line_base;
  logic [ADDR_W-1:0] addr_q;
  logic [WORD_W-1:0] cnt_q;
  logic [WORD_W-1:0] beat;
  logic [LINE_W-1:0] line_q;

  assign miss_addr = miss_addr_i;
  assign line_base = {miss_addr.line.num, {OFF_W{1'b0}}};
  // beats arrive in order from the line base
  assign beat      = WORD_W'(WORDS_PER_LINE - 1) - cnt_q;

  // request goes out in the same cycle as fill_start
  assign bus_req_o   = (state_q == IDLE && fill_start_i) || (state_q == WAIT_GNT);
  assign bus_addr_o  = (state_q == WAIT_GNT) ? addr_q : line_base;
  assign fill_err_o  = (state_q == BURST) && bus_err_i;
  assign fill_done_o = (state_q == BURST) && bus_ack_i && !bus_err_i && (cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (fill_start_i) begin
            state_q <= bus_gnt_i ? BURST : WAIT_GNT;
            cnt_q   <= WORD_W'(WORDS_PER_LINE - 1);
          end
        end
        WAIT_GNT: begin
          if (bus_gnt_i) begin
            state_q <= BURST;
          end
        end
        BURST: begin
          // error aborts, otherwise count beats down to zero
          if (bus_err_i || (bus_ack_i && cnt_q == '0)) begin
            state_q <= IDLE;
          end else if (bus_ack_i) begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    // address captured before the grant and held while waiting
    if (state_q == IDLE) begin
      addr_q <= line_base;
    end
    if (state_q == BURST && bus_ack_i) begin
      line_q[beat*DATA_W +: DATA_W] <= bus_rdata_i;
    end
  end

  // last beat passes straight through so the install sees the whole line
  always_comb begin
    line_o                        = line_q;
    line_o[beat*DATA_W +: DATA_W] = bus_rdata_i;
  end

  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o && !bus_gnt_i |=> bus_req_o && $stable(bus_addr_o));

endmodule

`default_nettype wire

// ==== hw/icache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_top
  import icache_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  // cpu fetch side
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              flush_i,
  output logic              ack_o,
  output logic              err_o,
  output logic [DATA_W-1:0] rdata_o,
  // line fill bus
  output logic              bus_req_o,
  output logic [ADDR_W-1:0] bus_addr_o,
  input  logic              bus_gnt_i,
  input  logic              bus_ack_i,
  input  logic [DATA_W-1:0] bus_rdata_i,
  input  logic              bus_err_i
);

  icache_addr_u      fetch_addr;
  logic [WAYS-1:0]   way_hit;
  logic              fill_start;
  logic              fill_done;
  logic              fill_err;
  logic [LINE_W-1:0] line_buf;
  logic [IDX_W-1:0]  lookup_idx;
  logic [WAYS-1:0]   fill_way;
  logic              fill_we;
  logic              inval;

  // cpu holds the address for the whole fetch
  assign fetch_addr = addr_i;

  icache_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .addr_i       (addr_i),
    .flush_i      (flush_i),
    .way_hit_i    (way_hit),
    .fill_done_i  (fill_done),
    .fill_err_i   (fill_err),
    .ack_o        (ack_o),
    .err_o        (err_o),
    .fill_start_o (fill_start),
    .lookup_idx_o (lookup_idx),
    .fill_way_o   (fill_way),
    .fill_we_o    (fill_we),
    .inval_o      (inval)
  );

  icache_tag_array u_tag_array (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lookup_idx_i (lookup_idx),
    .tag_i        (fetch_addr.lookup.tag),
    .fill_way_i   (fill_way),
    .fill_we_i    (fill_we),
    .inval_i      (inval),
    .way_hit_o    (way_hit)
  );

  icache_data_array u_data_array (
    .clk_i        (clk_i),
    .lookup_idx_i (lookup_idx),
    .word_sel_i   (fetch_addr.lookup.word),
    .fill_way_i   (fill_way),
    .fill_we_i    (fill_we),
    .line_i       (line_buf),
    .way_hit_i    (way_hit),
    .rdata_o      (rdata_o)
  );

  icache_burst u_burst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fill_start_i (fill_start),
    .miss_addr_i  (addr_i),
    .bus_req_o    (bus_req_o),
    .bus_addr_o   (bus_addr_o),
    .bus_gnt_i    (bus_gnt_i),
    .bus_ack_i    (bus_ack_i),
    .bus_rdata_i  (bus_rdata_i),
    .bus_err_i    (bus_err_i),
    .fill_done_o  (fill_done),
    .fill_err_o   (fill_err),
    .line_o       (line_buf)
  );

endmodule

`default_nettype wire

// ==== tb/tb_bus_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_bus_mem
  import icache_pkg::*;
#(
  parameter logic [DATA_W-1:0] MEM_KEY = 32'h5a5a_0000
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              bus_req_i,
  input  logic [ADDR_W-1:0] bus_addr_i,
  output logic              bus_gnt_o,
  output logic              bus_ack_o,
  output logic [DATA_W-1:0] bus_rdata_o,
  output logic              bus_err_o,
  output logic [31:0]       err_cnt_o
);

  // own random stream for grant delay, beat gaps and errors
  logic [31:0] lfsr_q = 32'h165e_08a5;

  // galois lfsr, one step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  initial begin
    logic [ADDR_W-1:0] base;
    int                delay;
    logic              abort;
    bus_gnt_o   = 1'b0;
    bus_ack_o   = 1'b0;
    bus_rdata_o = '0;
    bus_err_o   = 1'b0;
    err_cnt_o   = '0;
    forever begin
      // request sampled mid cycle, where it is stable
      @(negedge clk_i);
      if (rst_ni && bus_req_i) begin
        base  = bus_addr_i;
        delay = int'(take_bits(2));
        // 0 to 3 extra cycles before the grant
        repeat (delay) @(posedge clk_i);
        @(posedge clk_i);
        #1 bus_gnt_o = 1'b1;
        @(posedge clk_i);
        #1 bus_gnt_o = 1'b0;
        abort = 1'b0;
        for (int beat = 0; beat < WORDS_PER_LINE && !abort; beat++) begin
          // slow beat now and then
          if (take_bits(2) == 0) begin
            @(posedge clk_i);
            #1;
          end
          // error on about one beat in 32
          abort       = (take_bits(5) == 0);
          bus_ack_o   = !abort;
          bus_err_o   = abort;
          bus_rdata_o = (base + 32'(beat * 4)) ^ MEM_KEY;
          if (abort) begin
            err_cnt_o = err_cnt_o + 1;
          end
          @(posedge clk_i);
          #1;
          bus_ack_o = 1'b0;
          bus_err_o = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_icache.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_icache
  import icache_pkg::*;
();

  localparam int                CLK_PERIOD       = 8;
  localparam int                RESET_CYCLES     = 8;
  localparam int                NUM_ITER         = 300;
  // first fetch, repeat, and one after a flush or an error
  localparam int                FETCHES_PER_ITER = 3;
  localparam int                CYCLES_PER_FETCH = 64;
  // request cycle then one cycle of tag read
  localparam int                HIT_LAT          = 1;
  // 1 KB window is twice the cache so sets conflict
  localparam logic [ADDR_W-1:0] WIN_BASE         = 32'h0000_8000;
  localparam logic [DATA_W-1:0] MEM_KEY          = 32'h5a5a_0000;

  logic              clk;
  logic              rst_n;
  logic              req;
  logic [ADDR_W-1:0] addr;
  logic              flush;
  logic              ack;
  logic              err;
  logic [DATA_W-1:0] rdata;
  logic              bus_req;
  logic [ADDR_W-1:0] bus_addr;
  logic              bus_gnt;
  logic              bus_ack;
  logic [DATA_W-1:0] bus_rdata;
  logic              bus_err;
  logic [31:0]       err_cnt;

  logic [31:0]       lfsr_q         = 32'h165e_08a5;
  logic [ADDR_W-1:0] cur_addr       = '0;
  int                bus_req_cycles = 0;
  // results of the last fetch
  int                fetch_lat;
  logic              fetch_err;
  logic              req_seen;

  icache_top UUT (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_i       (req),
    .addr_i      (addr),
    .flush_i     (flush),
    .ack_o       (ack),
    .err_o       (err),
    .rdata_o     (rdata),
    .bus_req_o   (bus_req),
    .bus_addr_o  (bus_addr),
    .bus_gnt_i   (bus_gnt),
    .bus_ack_i   (bus_ack),
    .bus_rdata_i (bus_rdata),
    .bus_err_i   (bus_err)
  );

  tb_bus_mem #(.MEM_KEY(MEM_KEY)) u_mem (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .bus_req_i   (bus_req),
    .bus_addr_i  (bus_addr),
    .bus_gnt_o   (bus_gnt),
    .bus_ack_o   (bus_ack),
    .bus_rdata_o (bus_rdata),
    .bus_err_o   (bus_err),
    .err_cnt_o   (err_cnt)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  // one fetch held until ack or err and checked against the memory rule
  task automatic do_fetch(input string name, input logic [ADDR_W-1:0] a);
    int   errs_before;
    int   reqs_before;
    logic exp_err;
    @(posedge clk);
    #1;
    cur_addr    = a;
    addr        = a;
    req         = 1'b1;
    errs_before = int'(err_cnt);
    reqs_before = bus_req_cycles;
    fetch_lat   = 0;
    @(negedge clk);
    while (!ack && !err) begin
      fetch_lat++;
      @(negedge clk);
    end
    fetch_err = err;
    // err only when the slave injected one during this fetch
    exp_err = (int'(err_cnt) != errs_before);
    check($sformatf("%s err_o", name), 32'(exp_err), 32'(fetch_err));
    check($sformatf("%s ack_o", name), 32'(!exp_err), 32'(ack));
    if (!fetch_err) begin
      check($sformatf("%s rdata", name), a ^ MEM_KEY, rdata);
    end
    req_seen = (bus_req_cycles != reqs_before);
    // no fill means a hit with fixed timing
    if (!req_seen) begin
      check($sformatf("%s hit latency", name), 32'(HIT_LAT), 32'(fetch_lat));
    end
    @(posedge clk);
    #1;
    req = 1'b0;
  endtask

  task automatic pulse_flush();
    @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
  endtask

  // each bus request must name the base of the pending line
  always @(negedge clk) begin
    if (rst_n && bus_req) begin
      bus_req_cycles = bus_req_cycles + 1;
      check("bus_addr", cur_addr & ~ADDR_W'(LINE_BYTES - 1), bus_addr);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // clock, watchdog, stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (RESET_CYCLES + NUM_ITER * FETCHES_PER_ITER * CYCLES_PER_FETCH) @(posedge clk);
    $display("timeout: the cache stopped answering fetches");
    $display("Some tests failed");
    $fatal(1);
  end

  initial begin
    logic [31:0]       rnd;
    logic [ADDR_W-1:0] pick;
    rst_n = 1'b0;
    req   = 1'b0;
    addr  = '0;
    flush = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int i = 0; i < NUM_ITER; i++) begin
      // random word in the window
      rnd  = take_bits(8);
      pick = WIN_BASE + (rnd << 2);
      do_fetch("fetch", pick);
      if (!fetch_err) begin
        // line is now resident, so the same fetch must hit
        do_fetch("repeat", pick);
        check("repeat bus_req", 32'd0, 32'(req_seen));
        if (take_bits(3) == 0) begin
          pulse_flush();
          do_fetch("after flush", pick);
          check("after flush bus_req", 32'd1, 32'(req_seen));
        end
      end else begin
        // failed fill installs nothing
        do_fetch("after error", pick);
        check("after error bus_req", 32'd1, 32'(req_seen));
      end
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== icache_top.f ====
hw/icache_pkg.sv
hw/icache_ctrl.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_burst.sv
hw/icache_top.sv
tb/tb_bus_mem.sv
tb/tb_icache.sv

// ==== Makefile ====
TOP := tb_icache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f icache_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f icache_top.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
